// File: src/lcd_pkg.sv
package lcd_pkg;

	// timing base, kept small for simulation
	localparam int CLK_PER_US = 2;

	localparam int T_POWERUP_US = 500;
	localparam int T_PULSE_US = 10;               // init enable width
	localparam int T_INIT_FUNC_US = 0;
	localparam int T_INIT_DISP_US = 60;
	localparam int T_INIT_CLR_US = 120;
	localparam int T_INIT_ENTRY_US = 330;
	localparam int T_INIT_DONE_US = 440;

	localparam int T_CMD_SETUP_US = 1;            // rs/rw/data ahead of e
	localparam int T_CMD_HIGH_US = 13;
	localparam int T_CMD_TOTAL_US = 50;           // pop to next pop

	localparam int CFG_W = 7;                     // lines, font, on, cursor, blink, inc, shift
	localparam int CMD_W = 10;                    // rs, rw, data byte
	localparam int FIFO_DEPTH = 4;
	localparam int CNT_W = 3;
	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int TIMER_W = $clog2(T_POWERUP_US * CLK_PER_US + 1);

	localparam logic [3:0] ADDR_CONFIG = 4'h0;
	localparam logic [3:0] ADDR_CMD = 4'h4;
	localparam logic [3:0] ADDR_STATUS = 4'h8;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// lcd_ctrl states
	localparam logic [1:0] ST_POWERUP = 2'd0;
	localparam logic [1:0] ST_WAIT_CFG = 2'd1;
	localparam logic [1:0] ST_INIT = 2'd2;
	localparam logic [1:0] ST_READY = 2'd3;

endpackage

// File: src/lcd_axil_regs.sv
module lcd_axil_regs
	import lcd_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic [3:0]       s_awaddr,
	input  logic             s_awvalid,
	output logic             s_awready,
	input  logic [31:0]      s_wdata,
	input  logic             s_wvalid,
	output logic             s_wready,
	output logic [1:0]       s_bresp,
	output logic             s_bvalid,
	input  logic             s_bready,
	input  logic [3:0]       s_araddr,
	input  logic             s_arvalid,
	output logic             s_arready,
	output logic [31:0]      s_rdata,
	output logic [1:0]       s_rresp,
	output logic             s_rvalid,
	input  logic             s_rready,
	output logic             push,
	output logic [CMD_W-1:0] push_data,
	input  logic             fifo_full,
	input  logic [CNT_W-1:0] fifo_count,
	output logic [CFG_W-1:0] cfg,
	output logic             init_start,
	input  logic             cfg_ready,
	input  logic             init_done,
	input  logic             busy
);

	logic        wr_take;
	logic        rd_take;
	logic        cfg_ok;
	logic        cmd_ok;
	logic [31:0] rd_word;
	logic        rd_hit;

	// address and data accepted together, one outstanding response
	assign wr_take = s_awvalid && s_wvalid && !s_bvalid;
	assign s_awready = wr_take;
	assign s_wready = wr_take;

	assign cfg_ok = cfg_ready && (fifo_count == '0);
	assign cmd_ok = init_done && !fifo_full;     // only overflow guard in the design

	assign push = wr_take && (s_awaddr == ADDR_CMD) && cmd_ok;
	assign push_data = s_wdata[CMD_W-1:0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s_bvalid <= 1'b0;
			cfg <= '0;
			init_start <= 1'b0;
		end else begin
			init_start <= 1'b0;
			if (s_bvalid && s_bready)
				s_bvalid <= 1'b0;
			if (wr_take) begin
				s_bvalid <= 1'b1;
				if ((s_awaddr == ADDR_CONFIG) && cfg_ok) begin
					cfg <= s_wdata[CFG_W-1:0];
					init_start <= 1'b1;   // one cycle kick to lcd_ctrl
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_take) begin
			case (s_awaddr)
				ADDR_CONFIG: s_bresp <= cfg_ok ? RESP_OKAY : RESP_SLVERR;
				ADDR_CMD:    s_bresp <= cmd_ok ? RESP_OKAY : RESP_SLVERR;
				default:     s_bresp <= RESP_SLVERR;
			endcase
		end
	end

	assign s_arready = !s_rvalid;
	assign rd_take = s_arvalid && !s_rvalid;

	always_comb begin
		rd_word = '0;
		rd_hit = 1'b1;
		case (s_araddr)
			ADDR_CONFIG: rd_word = {{(32-CFG_W){1'b0}}, cfg};
			ADDR_STATUS: rd_word = {{(28-CNT_W){1'b0}}, fifo_count, 1'b0,
				fifo_full, init_done, busy};   // count sits at 6:4
			default:     rd_hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			s_rvalid <= 1'b0;
		else if (rd_take)
			s_rvalid <= 1'b1;
		else if (s_rready)
			s_rvalid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rd_take) begin
			s_rdata <= rd_word;
			s_rresp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
		end
	end

endmodule

// File: src/lcd_cmd_fifo.sv
module lcd_cmd_fifo
	import lcd_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             push,
	input  logic [CMD_W-1:0] push_data,
	input  logic             pop,
	output logic [CMD_W-1:0] head,
	output logic             empty,
	output logic             full,
	output logic [CNT_W-1:0] count
);

	logic [CMD_W-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;

	// oldest entry visible without a read cycle
	assign head = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == CNT_W'(FIFO_DEPTH));

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two, wraps
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: src/lcd_ctrl.sv
module lcd_ctrl
	import lcd_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic [CFG_W-1:0] cfg,
	input  logic             init_start,
	input  logic [CMD_W-1:0] head,
	input  logic             empty,
	output logic             pop,
	output logic             cfg_ready,
	output logic             init_done,
	output logic             busy,
	output logic             lcd_e,
	output logic             lcd_rs,
	output logic             lcd_rw,
	output logic [7:0]       lcd_data
);

	logic [1:0]         state;
	logic [TIMER_W-1:0] cnt;
	logic               active;     // a command window is running
	logic [CMD_W-1:0]   cmd_q;
	logic               init_e;
	logic [7:0]         init_byte;
	logic               cmd_e;

	// microseconds to clock cycles
	function automatic logic [TIMER_W-1:0] us(input int t_us);
		us = TIMER_W'(t_us * CLK_PER_US);
	endfunction

	function automatic logic in_win(input logic [TIMER_W-1:0] t, input int start_us,
			input int len_us);
		in_win = (t >= us(start_us)) && (t < us(start_us + len_us));
	endfunction

	assign pop = (state == ST_READY) && !active && !init_start && !empty;
	assign cfg_ready = (state == ST_WAIT_CFG) || ((state == ST_READY) && !active);
	assign busy = (state == ST_POWERUP) || (state == ST_INIT) || active || pop;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_POWERUP;
			cnt <= '0;
			init_done <= 1'b0;
			active <= 1'b0;
		end else begin
			case (state)
				ST_POWERUP: begin
					if (cnt == us(T_POWERUP_US) - 1'b1) begin
						state <= ST_WAIT_CFG;
						cnt <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				ST_WAIT_CFG: begin
					if (init_start) begin
						state <= ST_INIT;
						cnt <= '0;
					end
				end
				ST_INIT: begin
					if (cnt == us(T_INIT_DONE_US) - 1'b1) begin
						state <= ST_READY;
						cnt <= '0;
						init_done <= 1'b1;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin   // ST_READY
					if (active) begin
						// pop cycle plus this window spans the full command time
						if (cnt == us(T_CMD_TOTAL_US) - 2'd2) begin
							active <= 1'b0;
							cnt <= '0;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end else if (init_start) begin
						state <= ST_INIT;   // reconfigure from idle
						cnt <= '0;
						init_done <= 1'b0;
					end else if (pop) begin
						active <= 1'b1;
						cnt <= '0;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pop)
			cmd_q <= head;
	end

	// four init writes, data zero between pulses
	always_comb begin
		init_e = 1'b1;
		init_byte = 8'h00;
		if (in_win(cnt, T_INIT_FUNC_US, T_PULSE_US))
			init_byte = {4'b0011, cfg[6], cfg[5], 2'b00};
		else if (in_win(cnt, T_INIT_DISP_US, T_PULSE_US))
			init_byte = {5'b00001, cfg[4], cfg[3], cfg[2]};
		else if (in_win(cnt, T_INIT_CLR_US, T_PULSE_US))
			init_byte = 8'h01;
		else if (in_win(cnt, T_INIT_ENTRY_US, T_PULSE_US))
			init_byte = {6'b000001, cfg[1], cfg[0]};
		else
			init_e = 1'b0;
	end

	assign cmd_e = in_win(cnt, T_CMD_SETUP_US, T_CMD_HIGH_US);

	always_comb begin
		lcd_e = 1'b0;
		lcd_rs = 1'b0;
		lcd_rw = 1'b0;
		lcd_data = 8'h00;
		if (state == ST_INIT) begin
			lcd_e = init_e;
			lcd_data = init_byte;
		end else if (active) begin
			lcd_e = cmd_e;
			lcd_rs = cmd_q[CMD_W-1];
			lcd_rw = cmd_q[CMD_W-2];
			lcd_data = cmd_q[7:0];   // held across the whole window
		end
	end

endmodule

// File: src/lcd_sys.sv
module lcd_sys
	import lcd_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic [3:0]  s_awaddr,
	input  logic        s_awvalid,
	output logic        s_awready,
	input  logic [31:0] s_wdata,
	input  logic        s_wvalid,
	output logic        s_wready,
	output logic [1:0]  s_bresp,
	output logic        s_bvalid,
	input  logic        s_bready,
	input  logic [3:0]  s_araddr,
	input  logic        s_arvalid,
	output logic        s_arready,
	output logic [31:0] s_rdata,
	output logic [1:0]  s_rresp,
	output logic        s_rvalid,
	input  logic        s_rready,
	output logic        lcd_e,
	output logic        lcd_rs,
	output logic        lcd_rw,
	output logic [7:0]  lcd_data
);

	logic             push;
	logic [CMD_W-1:0] push_data;
	logic             pop;
	logic [CMD_W-1:0] head;
	logic             empty;
	logic             fifo_full;
	logic [CNT_W-1:0] fifo_count;
	logic [CFG_W-1:0] cfg;
	logic             init_start;
	logic             cfg_ready;
	logic             init_done;
	logic             busy;

	lcd_axil_regs u_regs (.*);

	lcd_cmd_fifo u_fifo (.clk, .rst_n, .push, .push_data, .pop, .head, .empty,
		.full(fifo_full), .count(fifo_count));

	lcd_ctrl u_ctrl (.clk, .rst_n, .cfg, .init_start, .head, .empty, .pop, .cfg_ready,
		.init_done, .busy, .lcd_e, .lcd_rs, .lcd_rw, .lcd_data);

endmodule

// File: bench/lcd_sys_properties.sv
module lcd_sys_properties
	import lcd_pkg::*;
(
	input logic       clk,
	input logic       rst_n,
	input logic       pop,
	input logic       lcd_e,
	input logic       lcd_rs,
	input logic       lcd_rw,
	input logic [7:0] lcd_data
);
	timeunit 1ns;
	timeprecision 100ps;

	int e_high;   // cycles lcd_e has been high so far

	always_ff @(posedge clk) begin
		if (!rst_n)
			e_high <= 0;
		else if (lcd_e)
			e_high <= e_high + 1;
		else
			e_high <= 0;
	end

	// pop cycle, then the setup time before the enable edge
	pop_to_e: assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> ##(T_CMD_SETUP_US * CLK_PER_US + 1) $rose(lcd_e))
		else $error("lcd_e did not rise one setup time after the pop cycle");

	pins_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(lcd_e && $past(lcd_e)) |-> $stable({lcd_rs, lcd_rw, lcd_data}))
		else $error("rs, rw or data changed while lcd_e was high");

	e_width: assert property (@(posedge clk) disable iff (!rst_n)
		lcd_e |-> (e_high < T_CMD_HIGH_US * CLK_PER_US))
		else $error("lcd_e stayed high longer than the command pulse");

endmodule

bind lcd_ctrl lcd_sys_properties props0 (
	.clk(clk),
	.rst_n(rst_n),
	.pop(pop),
	.lcd_e(lcd_e),
	.lcd_rs(lcd_rs),
	.lcd_rw(lcd_rw),
	.lcd_data(lcd_data)
);

// File: bench/lcd_sys_tb.sv
module lcd_sys_tb
	import lcd_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int OP_STAT = 0;
	localparam int OP_WR = 1;      // plain write, response only
	localparam int OP_CFG = 2;
	localparam int OP_CMD = 3;
	localparam int OP_RD = 4;
	localparam int OP_BURST = 5;
	localparam int OP_DRAIN = 6;   // wait idle, compare pin log
	localparam int N_ROWS = 17;
	localparam int WD_NS = (T_POWERUP_US + T_INIT_DONE_US + N_ROWS * T_CMD_TOTAL_US)
		* CLK_PER_US * 8 * 2;

	logic        clk;
	logic        rst_n;
	logic [3:0]  s_awaddr;
	logic        s_awvalid;
	logic        s_awready;
	logic [31:0] s_wdata;
	logic        s_wvalid;
	logic        s_wready;
	logic [1:0]  s_bresp;
	logic        s_bvalid;
	logic        s_bready;
	logic [3:0]  s_araddr;
	logic        s_arvalid;
	logic        s_arready;
	logic [31:0] s_rdata;
	logic [1:0]  s_rresp;
	logic        s_rvalid;
	logic        s_rready;
	logic        lcd_e;
	logic        lcd_rs;
	logic        lcd_rw;
	logic [7:0]  lcd_data;

	// op, address, data or expected status word, expected response
	int         tbl_op [N_ROWS] = '{OP_STAT, OP_WR, OP_CFG, OP_DRAIN, OP_CMD, OP_STAT,
		OP_WR, OP_RD, OP_DRAIN, OP_CMD, OP_CMD, OP_CMD, OP_DRAIN, OP_BURST, OP_DRAIN,
		OP_WR, OP_RD};
	logic [3:0] tbl_addr [N_ROWS] = '{ADDR_STATUS, ADDR_CMD, ADDR_CONFIG, ADDR_STATUS,
		ADDR_CMD, ADDR_STATUS, ADDR_CONFIG, 4'hc, ADDR_STATUS, ADDR_CMD, ADDR_CMD,
		ADDR_CMD, ADDR_STATUS, ADDR_CMD, ADDR_STATUS, ADDR_STATUS, ADDR_CONFIG};
	logic [31:0] tbl_data [N_ROWS] = '{32'h1, 32'h241, 32'h5a, 32'h0, 32'h241, 32'h3,
		32'h7f, 32'h0, 32'h0, 32'h038, 32'h3c5, 32'h10f, 32'h0, 32'h0, 32'h0, 32'h1,
		32'h5a};
	logic [1:0] tbl_resp [N_ROWS] = '{RESP_OKAY, RESP_SLVERR, RESP_OKAY, RESP_OKAY,
		RESP_OKAY, RESP_OKAY, RESP_SLVERR, RESP_SLVERR, RESP_OKAY, RESP_OKAY, RESP_OKAY,
		RESP_OKAY, RESP_OKAY, RESP_OKAY, RESP_OKAY, RESP_SLVERR, RESP_OKAY};

	logic [CMD_W-1:0] exp_cmd [$];
	int               exp_width [$];
	logic [CMD_W-1:0] seen_cmd [$];
	int               seen_width [$];
	logic             e_prev = 1'b0;
	logic [CMD_W-1:0] cur_cmd;
	int               cur_width;

	lcd_sys dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// pin monitor, one record per enable pulse
	always @(negedge clk) begin
		if (lcd_e && !e_prev) begin
			cur_cmd = {lcd_rs, lcd_rw, lcd_data};
			cur_width = 1;
		end else if (lcd_e) begin
			cur_width = cur_width + 1;
		end else if (e_prev) begin
			seen_cmd.push_back(cur_cmd);
			seen_width.push_back(cur_width);
		end
		e_prev = lcd_e;
	end

	task automatic abort_run();
		$display("Result: FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
		if (exp !== act) begin
			$display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_cmd(input string name, input logic [CMD_W-1:0] exp,
			input logic [CMD_W-1:0] act);
		if (exp !== act) begin
			$display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_rdata(input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("MISMATCH time=%0t signal=s_rdata expected=%h actual=%h", $time, exp, act);
			abort_run();
		end
	endtask

	// fields compared as {count, full, init_done, busy}
	task automatic check_status(input logic [31:0] word, input logic exp_busy,
			input logic exp_init, input logic exp_full, input logic [CNT_W-1:0] exp_cnt);
		if ({word[6:4], word[2:0]} !== {exp_cnt, exp_full, exp_init, exp_busy}) begin
			$display("MISMATCH time=%0t signal=status expected=%h actual=%h", $time,
				{exp_cnt, 1'b0, exp_full, exp_init, exp_busy}, word[6:0]);
			abort_run();
		end
	endtask

	task automatic check_width(input string name, input int exp, input int act);
		if (exp != act) begin
			$display("MISMATCH time=%0t signal=%s expected=%0d actual=%0d", $time, name, exp, act);
			abort_run();
		end
	endtask

	function automatic logic [7:0] expected_init_byte(input logic [CFG_W-1:0] c, input int step);
		case (step)
			0:       return {4'b0011, c[6], c[5], 2'b00};   // function set
			1:       return {5'b00001, c[4:2]};
			2:       return 8'h01;
			default: return {6'b000001, c[1:0]};           // entry mode
		endcase
	endfunction

	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		@(negedge clk);
		s_awaddr = addr;
		s_wdata = data;
		s_awvalid = 1'b1;
		s_wvalid = 1'b1;
		#1;
		while (!(s_awready && s_wready)) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);   // taken on the rising edge just passed
		s_awvalid = 1'b0;
		s_wvalid = 1'b0;
		while (!s_bvalid)
			@(negedge clk);
		resp = s_bresp;
	endtask

	task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		@(negedge clk);
		s_araddr = addr;
		s_arvalid = 1'b1;
		#1;
		while (!s_arready) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		s_arvalid = 1'b0;
		while (!s_rvalid)
			@(negedge clk);
		data = s_rdata;
		resp = s_rresp;
	endtask

	task automatic wait_idle(output logic [31:0] word);
		logic [1:0] resp;
		word = 32'h1;
		while (word[0])
			axi_read(ADDR_STATUS, word, resp);
	endtask

	task automatic drain_and_compare();
		logic [31:0] word;
		wait_idle(word);
		check_status(word, 1'b0, 1'b1, 1'b0, '0);
		if (seen_cmd.size() != exp_cmd.size()) begin
			$display("pin monitor saw %0d enable pulses but %0d were expected at time %0t",
				seen_cmd.size(), exp_cmd.size(), $time);
			abort_run();
		end
		while (exp_cmd.size() > 0) begin
			check_cmd("lcd_rs_rw_data", exp_cmd.pop_front(), seen_cmd.pop_front());
			check_width("lcd_e_width", exp_width.pop_front(), seen_width.pop_front());
		end
	endtask

	task automatic run_burst();
		logic [31:0]      rnd;
		logic [CMD_W-1:0] cmd;
		logic [1:0]       resp;
		for (int j = 0; j < 10; j++) begin
			rnd = $urandom;
			cmd = rnd[CMD_W-1:0];
			axi_write(ADDR_CMD, {22'b0, cmd}, resp);
			// first one popped at once, then the FIFO fills up
			if (j < FIFO_DEPTH + 1) begin
				check_resp("s_bresp", RESP_OKAY, resp);
				exp_cmd.push_back(cmd);
				exp_width.push_back(T_CMD_HIGH_US * CLK_PER_US);
			end else begin
				check_resp("s_bresp", RESP_SLVERR, resp);
			end
		end
	endtask

	initial begin
		logic [31:0] word;
		logic [1:0]  resp;
		void'($urandom(32'h976d_a8a2));
		rst_n = 1'b0;
		s_awaddr = '0;
		s_awvalid = 1'b0;
		s_wdata = '0;
		s_wvalid = 1'b0;
		s_bready = 1'b1;
		s_araddr = '0;
		s_arvalid = 1'b0;
		s_rready = 1'b1;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		check_cmd("lcd_rs_rw_data", '0, {lcd_rs, lcd_rw, lcd_data});

		for (int i = 0; i < N_ROWS; i++) begin
			case (tbl_op[i])
				OP_CFG, OP_CMD, OP_WR: begin
					if (tbl_op[i] == OP_CFG)
						wait_idle(word);   // power-up wait must be over
					axi_write(tbl_addr[i], tbl_data[i], resp);
					check_resp("s_bresp", tbl_resp[i], resp);
					if (tbl_op[i] == OP_CFG) begin
						for (int k = 0; k < 4; k++) begin
							exp_cmd.push_back({2'b00, expected_init_byte(tbl_data[i][CFG_W-1:0], k)});
							exp_width.push_back(T_PULSE_US * CLK_PER_US);
						end
					end else if (tbl_op[i] == OP_CMD) begin
						exp_cmd.push_back(tbl_data[i][CMD_W-1:0]);
						exp_width.push_back(T_CMD_HIGH_US * CLK_PER_US);
					end
				end
				OP_STAT: begin
					axi_read(tbl_addr[i], word, resp);
					check_resp("s_rresp", tbl_resp[i], resp);
					check_status(word, tbl_data[i][0], tbl_data[i][1], tbl_data[i][2],
						tbl_data[i][6:4]);
				end
				OP_RD: begin
					axi_read(tbl_addr[i], word, resp);
					check_resp("s_rresp", tbl_resp[i], resp);
					check_rdata(tbl_data[i], word);
				end
				OP_BURST: run_burst();
				default:  drain_and_compare();
			endcase
		end

		$display("Result: PASSED");
		$finish;
	end

	initial begin
		#(WD_NS);
		$display("run timed out after %0d ns before the test table finished", WD_NS);
		abort_run();
	end

endmodule

// File: lcd_sys.f
src/lcd_pkg.sv
src/lcd_axil_regs.sv
src/lcd_cmd_fifo.sv
src/lcd_ctrl.sv
src/lcd_sys.sv
bench/lcd_sys_properties.sv
bench/lcd_sys_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build lcd_sys with its testbench in verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module lcd_sys_tb -f lcd_sys.f -o lcd_sim \
	> sim.log 2>&1 \
	&& ./obj_dir/lcd_sim >> sim.log 2>&1 \
	|| { cat sim.log; echo "build or simulation exited with an error"; exit 1; }

cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0
